//--- bowling_pkg.sv
package bowling_pkg;

    // pin count and visible screen area in pixels
    localparam int NUM_PINS      = 10;
    localparam int SCREEN_WIDTH  = 1024;
    localparam int SCREEN_HEIGHT = 768;

    // coordinates in pixels
    typedef logic [10:0] pos_x_t;
    typedef logic [9:0]  pos_y_t;

    // velocity magnitude in pixels per step, sign of y is kept apart
    typedef logic [15:0] vel_t;

    // one bit per pin
    typedef logic [NUM_PINS-1:0] pin_mask_t;

    // steps in one run
    typedef logic [15:0] step_cnt_t;

    // apb widths
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map
    localparam apb_addr_t REG_CTRL       = 8'h00;
    localparam apb_addr_t REG_STATUS     = 8'h04;
    localparam apb_addr_t REG_BALL_START = 8'h08;
    localparam apb_addr_t REG_BALL_VEL   = 8'h0C;
    localparam apb_addr_t REG_CFG        = 8'h10;
    localparam apb_addr_t REG_KNOCKED    = 8'h14;
    localparam apb_addr_t REG_BALL_POS   = 8'h18;
    // pin i sits at REG_PIN_BASE + 4*i
    localparam apb_addr_t REG_PIN_BASE   = 8'h20;

    // one step walks BALL, CONTACT, PINS in that order
    typedef enum logic [2:0] {
        IDLE,
        BALL,
        CONTACT,
        PINS,
        DONE
    } seq_state_t;

endpackage

//--- bowling_ifs.sv
interface pin_step_if (
    // direction flag comes straight from the held settings
    input logic is_vy_neg
);

    // high for the PINS cycle of each step
    logic                                          valid;
    // velocity each knocked pin took on at contact
    bowling_pkg::vel_t [bowling_pkg::NUM_PINS-1:0] pins_vx;
    bowling_pkg::vel_t [bowling_pkg::NUM_PINS-1:0] pins_vy;
    // knocked mask, sticky until rack
    bowling_pkg::pin_mask_t                        pins_hit;

    // contact stage owns the per-pin data
    modport sender (output pins_vx, output pins_vy, output pins_hit);

    // sequencer owns the timing
    modport control (output valid);

    // pin field consumes everything
    modport receiver (input valid, input is_vy_neg, input pins_vx, input pins_vy,
                      input pins_hit);

endinterface

//--- bowling_regs.sv
module bowling_regs (
    input  logic                                            clk_in,
    input  logic                                            rst_in,
    input  logic                                            psel,
    input  logic                                            penable,
    input  logic                                            pwrite,
    input  bowling_pkg::apb_addr_t                          paddr,
    input  bowling_pkg::apb_data_t                          pwdata,
    input  logic                                            busy,
    input  logic                                            done,
    input  bowling_pkg::pos_x_t                             ball_x,
    input  bowling_pkg::pos_y_t                             ball_y,
    input  bowling_pkg::pin_mask_t                          knocked,
    input  bowling_pkg::pos_x_t [bowling_pkg::NUM_PINS-1:0] pins_x,
    input  bowling_pkg::pos_y_t [bowling_pkg::NUM_PINS-1:0] pins_y,
    output bowling_pkg::apb_data_t                          prdata,
    output logic                                            pready,
    output logic                                            pslverr,
    output logic                                            launch,
    output logic                                            rack,
    output bowling_pkg::pos_x_t                             start_x,
    output bowling_pkg::pos_y_t                             start_y,
    output bowling_pkg::vel_t                               ball_vx,
    output bowling_pkg::vel_t                               ball_vy,
    output bowling_pkg::step_cnt_t                          steps,
    output logic                                            vy_neg
);

    logic                   access;
    logic                   wr_en;
    logic                   pin_sel;
    bowling_pkg::apb_addr_t pin_off;
    logic [3:0]             pin_idx;
    logic                   addr_ok;
    logic                   read_only;

    // no wait states, every transfer ends in its access phase
    assign pready = 1'b1;
    assign access = psel && penable;
    assign wr_en  = access && pwrite && !pslverr;

    // pin window is word aligned, ten entries
    assign pin_off = paddr - bowling_pkg::REG_PIN_BASE;
    assign pin_idx = pin_off[5:2];
    assign pin_sel = (paddr >= bowling_pkg::REG_PIN_BASE) && (paddr[1:0] == 2'b00) &&
                     (paddr < bowling_pkg::REG_PIN_BASE +
                              bowling_pkg::apb_addr_t'(4 * bowling_pkg::NUM_PINS));

    // address decode and read mux
    always_comb begin
        prdata    = '0;
        addr_ok   = 1'b1;
        read_only = 1'b1;
        case (paddr)
            // ctrl reads back as zero
            bowling_pkg::REG_CTRL:       read_only = 1'b0;
            bowling_pkg::REG_STATUS:     prdata = {30'b0, done, busy};
            bowling_pkg::REG_BALL_START: begin
                prdata    = {6'b0, start_y, 5'b0, start_x};
                read_only = 1'b0;
            end
            bowling_pkg::REG_BALL_VEL: begin
                prdata    = {ball_vy, ball_vx};
                read_only = 1'b0;
            end
            bowling_pkg::REG_CFG: begin
                prdata    = {15'b0, vy_neg, steps};
                read_only = 1'b0;
            end
            bowling_pkg::REG_KNOCKED:    prdata = {22'b0, knocked};
            bowling_pkg::REG_BALL_POS:   prdata = {6'b0, ball_y, 5'b0, ball_x};
            default: begin
                if (pin_sel) begin
                    prdata = {6'b0, pins_y[pin_idx], 5'b0, pins_x[pin_idx]};
                end else begin
                    addr_ok = 1'b0;
                end
            end
        endcase
    end

    // unmapped offset or write to a status/readback register
    assign pslverr = access && (!addr_ok || (pwrite && read_only));

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            launch  <= 1'b0;
            rack    <= 1'b0;
            start_x <= '0;
            start_y <= '0;
            ball_vx <= '0;
            ball_vy <= '0;
            steps   <= '0;
            vy_neg  <= 1'b0;
        end else begin
            // rack wins if both control bits are written together
            rack   <= wr_en && (paddr == bowling_pkg::REG_CTRL) && pwdata[1];
            launch <= wr_en && (paddr == bowling_pkg::REG_CTRL) && pwdata[0] &&
                      !pwdata[1] && !busy;
            // settings are frozen for the length of a run
            if (wr_en && !busy) begin
                case (paddr)
                    bowling_pkg::REG_BALL_START: begin
                        start_x <= pwdata[10:0];
                        start_y <= pwdata[25:16];
                    end
                    bowling_pkg::REG_BALL_VEL: begin
                        ball_vx <= pwdata[15:0];
                        ball_vy <= pwdata[31:16];
                    end
                    bowling_pkg::REG_CFG: begin
                        steps  <= pwdata[15:0];
                        vy_neg <= pwdata[16];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- lane_sequencer.sv
module lane_sequencer (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   launch,
    input  logic                   rack,
    input  bowling_pkg::step_cnt_t steps,
    output logic                   ball_step,
    output logic                   contact_en,
    output logic                   busy,
    output logic                   done,
    pin_step_if.control            step
);

    bowling_pkg::seq_state_t state;
    // steps still to run, including the current one
    bowling_pkg::step_cnt_t  remaining;

    always_ff @(posedge clk_in) begin
        if (rst_in || rack) begin
            state     <= bowling_pkg::IDLE;
            remaining <= '0;
            done      <= 1'b0;
        end else begin
            case (state)
                bowling_pkg::IDLE: begin
                    if (launch) begin
                        done      <= 1'b0;
                        remaining <= steps;
                        // zero steps still passes through DONE once
                        state     <= (steps == '0) ? bowling_pkg::DONE : bowling_pkg::BALL;
                    end
                end
                bowling_pkg::BALL:    state <= bowling_pkg::CONTACT;
                bowling_pkg::CONTACT: state <= bowling_pkg::PINS;
                bowling_pkg::PINS: begin
                    remaining <= remaining - bowling_pkg::step_cnt_t'(1);
                    if (remaining == bowling_pkg::step_cnt_t'(1)) begin
                        state <= bowling_pkg::DONE;
                    end else begin
                        state <= bowling_pkg::BALL;
                    end
                end
                bowling_pkg::DONE: begin
                    // done rises on the same edge busy falls
                    done  <= 1'b1;
                    state <= bowling_pkg::IDLE;
                end
                default: state <= bowling_pkg::IDLE;
            endcase
        end
    end

    // one-hot strobes for the three stages
    assign ball_step  = (state == bowling_pkg::BALL);
    assign contact_en = (state == bowling_pkg::CONTACT);
    assign step.valid = (state == bowling_pkg::PINS);
    // busy covers the DONE cycle too
    assign busy       = (state != bowling_pkg::IDLE);

endmodule

//--- ball_motion.sv
module ball_motion (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                launch,
    input  logic                rack,
    input  logic                ball_step,
    input  bowling_pkg::pos_x_t start_x,
    input  bowling_pkg::pos_y_t start_y,
    input  bowling_pkg::vel_t   ball_vx,
    input  bowling_pkg::vel_t   ball_vy,
    input  logic                vy_neg,
    output bowling_pkg::pos_x_t ball_x,
    output bowling_pkg::pos_y_t ball_y
);

    logic                on_screen;
    bowling_pkg::pos_x_t next_x;
    bowling_pkg::pos_y_t next_y;

    // a ball past either edge is frozen where it is
    assign on_screen = (ball_x < bowling_pkg::SCREEN_WIDTH) &&
                       (ball_y < bowling_pkg::SCREEN_HEIGHT);

    // sums wrap at the coordinate width
    // a ball moving up past row 0 lands at a large y and so leaves the screen
    always_comb begin
        next_x = bowling_pkg::pos_x_t'(ball_x + ball_vx);
        if (vy_neg) begin
            next_y = bowling_pkg::pos_y_t'(ball_y - ball_vy);
        end else begin
            next_y = bowling_pkg::pos_y_t'(ball_y + ball_vy);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || rack) begin
            ball_x <= '0;
            ball_y <= '0;
        end else if (launch) begin
            // start position loads on the launch edge
            ball_x <= start_x;
            ball_y <= start_y;
        end else if (ball_step && on_screen) begin
            ball_x <= next_x;
            ball_y <= next_y;
        end
    end

endmodule

//--- pin_contact.sv
module pin_contact #(
    parameter int HIT_RADIUS = 16
) (
    input  logic                                            clk_in,
    input  logic                                            rst_in,
    input  logic                                            rack,
    input  logic                                            contact_en,
    input  bowling_pkg::pos_x_t                             ball_x,
    input  bowling_pkg::pos_y_t                             ball_y,
    input  bowling_pkg::vel_t                               ball_vx,
    input  bowling_pkg::vel_t                               ball_vy,
    input  bowling_pkg::pos_x_t [bowling_pkg::NUM_PINS-1:0] pins_x,
    input  bowling_pkg::pos_y_t [bowling_pkg::NUM_PINS-1:0] pins_y,
    pin_step_if.sender                                      step
);

    // per-axis absolute distance from ball to each pin
    bowling_pkg::pos_x_t    dist_x [bowling_pkg::NUM_PINS];
    bowling_pkg::pos_y_t    dist_y [bowling_pkg::NUM_PINS];
    bowling_pkg::pin_mask_t near;
    // pins knocked on this contact cycle only
    bowling_pkg::pin_mask_t new_hit;

    // all ten comparisons run in parallel
    always_comb begin
        for (int i = 0; i < bowling_pkg::NUM_PINS; i++) begin
            if (ball_x >= pins_x[i]) begin
                dist_x[i] = ball_x - pins_x[i];
            end else begin
                dist_x[i] = pins_x[i] - ball_x;
            end
            if (ball_y >= pins_y[i]) begin
                dist_y[i] = ball_y - pins_y[i];
            end else begin
                dist_y[i] = pins_y[i] - ball_y;
            end
            // hit only when strictly inside the radius on both axes
            near[i] = (dist_x[i] < HIT_RADIUS) && (dist_y[i] < HIT_RADIUS);
        end
    end

    // a pin already down keeps its first velocity
    assign new_hit = {bowling_pkg::NUM_PINS{contact_en}} & near & ~step.pins_hit;

    always_ff @(posedge clk_in) begin
        if (rst_in || rack) begin
            step.pins_hit <= '0;
        end else begin
            step.pins_hit <= step.pins_hit | new_hit;
        end
    end

    // each newly knocked pin copies the ball velocity
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < bowling_pkg::NUM_PINS; i++) begin
            if (new_hit[i]) begin
                step.pins_vx[i] <= ball_vx;
                step.pins_vy[i] <= ball_vy;
            end
        end
    end

endmodule

//--- pin_field.sv
module pin_field (
    input  logic                                            clk_in,
    input  logic                                            rst_in,
    input  logic                                            rack,
    pin_step_if.receiver                                    step,
    output bowling_pkg::pos_x_t [bowling_pkg::NUM_PINS-1:0] pins_x,
    output bowling_pkg::pos_y_t [bowling_pkg::NUM_PINS-1:0] pins_y
);

    // racked triangle, pin 0 first
    // back row of four, then three, two, and the head pin
    localparam bowling_pkg::pos_x_t RACK_X [bowling_pkg::NUM_PINS] = '{
        11'd0,   11'd96,  11'd192, 11'd288,
        11'd48,  11'd144, 11'd240,
        11'd96,  11'd192,
        11'd144
    };
    localparam bowling_pkg::pos_y_t RACK_Y [bowling_pkg::NUM_PINS] = '{
        10'd0,   10'd0,   10'd0,   10'd0,
        10'd60,  10'd60,  10'd60,
        10'd120, 10'd120,
        10'd180
    };

    // pins that may still move this step
    bowling_pkg::pin_mask_t movable;

    always_comb begin
        for (int i = 0; i < bowling_pkg::NUM_PINS; i++) begin
            movable[i] = step.pins_hit[i] &&
                         (pins_x[i] < bowling_pkg::SCREEN_WIDTH) &&
                         (pins_y[i] < bowling_pkg::SCREEN_HEIGHT);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || rack) begin
            for (int i = 0; i < bowling_pkg::NUM_PINS; i++) begin
                pins_x[i] <= RACK_X[i];
                pins_y[i] <= RACK_Y[i];
            end
        end else if (step.valid) begin
            for (int i = 0; i < bowling_pkg::NUM_PINS; i++) begin
                if (movable[i]) begin
                    // x only ever grows
                    pins_x[i] <= bowling_pkg::pos_x_t'(pins_x[i] + step.pins_vx[i]);
                    // y follows the shared direction flag
                    if (step.is_vy_neg) begin
                        pins_y[i] <= bowling_pkg::pos_y_t'(pins_y[i] - step.pins_vy[i]);
                    end else begin
                        pins_y[i] <= bowling_pkg::pos_y_t'(pins_y[i] + step.pins_vy[i]);
                    end
                end
            end
        end
    end

endmodule

//--- bowling_lane_top.sv
module bowling_lane_top #(
    parameter int HIT_RADIUS = 16
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  bowling_pkg::apb_addr_t paddr,
    input  bowling_pkg::apb_data_t pwdata,
    output bowling_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr
);

    // control between registers and sequencer
    logic                   launch;
    logic                   rack;
    logic                   busy;
    logic                   done;
    logic                   ball_step;
    logic                   contact_en;

    // held launch settings
    bowling_pkg::pos_x_t    start_x;
    bowling_pkg::pos_y_t    start_y;
    bowling_pkg::vel_t      ball_vx;
    bowling_pkg::vel_t      ball_vy;
    bowling_pkg::step_cnt_t steps;
    logic                   vy_neg;

    // live positions
    bowling_pkg::pos_x_t                             ball_x;
    bowling_pkg::pos_y_t                             ball_y;
    bowling_pkg::pos_x_t [bowling_pkg::NUM_PINS-1:0] pins_x;
    bowling_pkg::pos_y_t [bowling_pkg::NUM_PINS-1:0] pins_y;

    // per-step pin update bundle
    pin_step_if step_if (.is_vy_neg(vy_neg));

    bowling_regs u_regs (
        .clk_in, .rst_in, .psel, .penable, .pwrite, .paddr, .pwdata,
        .busy, .done, .ball_x, .ball_y,
        .knocked (step_if.pins_hit),
        .pins_x, .pins_y, .prdata, .pready, .pslverr, .launch, .rack,
        .start_x, .start_y, .ball_vx, .ball_vy, .steps, .vy_neg
    );

    lane_sequencer u_seq (
        .clk_in, .rst_in, .launch, .rack, .steps,
        .ball_step, .contact_en, .busy, .done,
        .step (step_if.control)
    );

    ball_motion u_ball (
        .clk_in, .rst_in, .launch, .rack, .ball_step,
        .start_x, .start_y, .ball_vx, .ball_vy, .vy_neg, .ball_x, .ball_y
    );

    pin_contact #(.HIT_RADIUS(HIT_RADIUS)) u_contact (
        .clk_in, .rst_in, .rack, .contact_en,
        .ball_x, .ball_y, .ball_vx, .ball_vy, .pins_x, .pins_y,
        .step (step_if.sender)
    );

    pin_field u_pins (
        .clk_in, .rst_in, .rack,
        .step (step_if.receiver),
        .pins_x, .pins_y
    );

endmodule

//--- bowling_lane_properties.sv
module bowling_lane_properties (
    input logic clk_in,
    input logic rst_in,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic busy,
    input logic done,
    input logic valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions for the end of run summary
    int fail_count = 0;

    // access phase only directly after a setup cycle of the same transfer
    a_apb_setup: assert property (@(posedge clk_in) disable iff (rst_in)
        penable |-> psel && $past(psel) && !$past(penable))
        else begin
            $error("penable high without a preceding psel setup cycle");
            fail_count++;
        end

    // slave has no wait states
    a_apb_ready: assert property (@(posedge clk_in) disable iff (rst_in) pready)
        else begin
            $error("pready went low");
            fail_count++;
        end

    // done only rises once busy has dropped
    a_busy_done: assert property (@(posedge clk_in) disable iff (rst_in) !(busy && done))
        else begin
            $error("busy and done high together");
            fail_count++;
        end

    // pin updates belong to a run
    a_valid_busy: assert property (@(posedge clk_in) disable iff (rst_in) valid |-> busy)
        else begin
            $error("pin step valid outside a run");
            fail_count++;
        end

endmodule

//--- tb_bowling_lane.sv
module tb_bowling_lane;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk_in;
    logic                   rst_in;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    bowling_pkg::apb_addr_t paddr;
    bowling_pkg::apb_data_t pwdata;
    bowling_pkg::apb_data_t prdata;
    logic                   pready;
    logic                   pslverr;

    // each pattern line holds op, address, data and expected value as four words
    logic [31:0] pat [0:255];
    int          errors;
    int          checks;
    int          tests;
    int          test_id;
    int          test_errors;

    bowling_lane_top #(.HIT_RADIUS(16)) DUT (.*);

    bind bowling_lane_top bowling_lane_properties u_props (
        .clk_in, .rst_in, .psel, .penable, .pready, .busy, .done,
        .valid (step_if.valid)
    );

    always #50 clk_in = ~clk_in;

    function automatic string reg_name(input bowling_pkg::apb_addr_t addr);
        case (addr)
            8'h04:   return "REG_STATUS";
            8'h08:   return "REG_BALL_START";
            8'h0C:   return "REG_BALL_VEL";
            8'h10:   return "REG_CFG";
            8'h14:   return "REG_KNOCKED";
            8'h18:   return "REG_BALL_POS";
            default: return $sformatf("register at %h", addr);
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
        errors++;
        test_errors++;
    endtask

    // setup and access each start on a falling edge and read data is sampled before the rise
    task automatic apb_xfer(
        input  logic                   wr,
        input  bowling_pkg::apb_addr_t addr,
        input  bowling_pkg::apb_data_t data,
        output bowling_pkg::apb_data_t rdata,
        output logic                   err
    );
        int wait_cnt;
        @(negedge clk_in);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk_in);
        penable  = 1'b1;
        wait_cnt = 0;
        #20;
        // pready low extends the access phase
        while (!pready && wait_cnt < 16) begin
            @(negedge clk_in);
            #20;
            wait_cnt++;
        end
        if (!pready) begin
            $display("APB transfer to %s never completed, pready stayed low", reg_name(addr));
            errors++;
            test_errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_in);
        @(negedge clk_in);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic end_test();
        if (test_id != 0) begin
            tests++;
            $display("test %0d finished with %0d errors", test_id, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        bowling_pkg::apb_data_t rdata;
        logic                   err;
        logic                   running;
        int                     idx;
        int                     polls;

        clk_in      = 1'b0;
        rst_in      = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_id     = 0;
        test_errors = 0;
        $readmemh("bowling_patterns.txt", pat);
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in  = 1'b0;
        idx     = 0;
        running = 1'b1;
        while (running) begin
            case (pat[idx])
                32'h0: begin
                    end_test();
                    test_id = pat[idx+2];
                end
                32'h1: begin
                    apb_xfer(1'b1, pat[idx+1][7:0], pat[idx+2], rdata, err);
                    checks++;
                    if (err !== 1'b0) report_mismatch("pslverr", 32'h0, {31'b0, err});
                end
                32'h2: begin
                    apb_xfer(1'b0, pat[idx+1][7:0], '0, rdata, err);
                    checks += 2;
                    if (err !== 1'b0) report_mismatch("pslverr", 32'h0, {31'b0, err});
                    if (rdata !== pat[idx+3]) begin
                        report_mismatch(reg_name(pat[idx+1][7:0]), pat[idx+3], rdata);
                    end
                end
                32'h3: begin
                    // keep reading until the run reports done
                    polls = 0;
                    do begin
                        apb_xfer(1'b0, pat[idx+1][7:0], '0, rdata, err);
                        polls++;
                    end while (rdata !== pat[idx+3] && polls < pat[idx+2]);
                    checks++;
                    if (rdata !== pat[idx+3]) begin
                        $display("timeout: %s did not reach %h within %0d reads",
                                 reg_name(pat[idx+1][7:0]), pat[idx+3], polls);
                        errors++;
                        test_errors++;
                    end
                end
                32'h4: begin
                    apb_xfer(1'b1, pat[idx+1][7:0], pat[idx+2], rdata, err);
                    checks++;
                    if (err !== 1'b1) report_mismatch("pslverr", 32'h1, {31'b0, err});
                end
                32'hf: running = 1'b0;
                default: begin
                    $display("pattern line %0d holds no known operation", idx / 4);
                    errors++;
                    running = 1'b0;
                end
            endcase
            idx += 4;
        end
        end_test();
        if (DUT.u_props.fail_count != 0) begin
            $display("%0d concurrent assertions failed during the run",
                     DUT.u_props.fail_count);
            errors += DUT.u_props.fail_count;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- bowling_lane_top.f
bowling_pkg.sv
bowling_ifs.sv
bowling_regs.sv
lane_sequencer.sv
ball_motion.sv
pin_contact.sv
pin_field.sv
bowling_lane_top.sv
bowling_lane_properties.sv
tb_bowling_lane.sv

//--- Bender.yml
package:
  name: bowling_lane

sources:
  - bowling_pkg.sv
  - bowling_ifs.sv
  - bowling_regs.sv
  - lane_sequencer.sv
  - ball_motion.sv
  - pin_contact.sv
  - pin_field.sv
  - bowling_lane_top.sv
  - target: test
    files:
      - bowling_lane_properties.sv
      - tb_bowling_lane.sv

//--- bowling_patterns.txt
// op addr data expect; op 0 starts test <data>, 1 write, 2 read and compare
// 3 poll addr until expect, at most <data> reads, 4 write that must raise pslverr, f end
0 00 00000001 00000000
2 04 00000000 00000000
2 14 00000000 00000000
2 20 00000000 00000000
2 2c 00000000 00000120
2 38 00000000 003c00f0
2 40 00000000 007800c0
2 44 00000000 00b40090
0 00 00000002 00000000
1 08 012c0090 00000000
1 0c 00140000 00000000
1 10 00010014 00000000
1 00 00000001 00000000
3 04 00000040 00000002
2 14 00000000 00000220
2 18 00000000 03ec0090
2 34 00000000 03ec0090
2 44 00000000 03ec0090
2 3c 00000000 00780060
0 00 00000004 00000000
1 00 00000001 00000000
3 04 00000040 00000002
2 14 00000000 00000220
2 18 00000000 03ec0090
2 44 00000000 03ec0090
0 00 00000005 00000000
1 00 00000002 00000000
2 04 00000000 00000000
2 14 00000000 00000000
2 18 00000000 00000000
2 34 00000000 003c0090
2 44 00000000 00b40090
1 00 00000001 00000000
1 0c 00140005 00000000
1 10 00000003 00000000
3 04 00000040 00000002
2 14 00000000 00000220
2 18 00000000 03ec0090
2 0c 00000000 00140000
2 10 00000000 00010014
0 00 00000003 00000000
1 00 00000002 00000000
1 08 025801f4 00000000
1 0c 0014000a 00000000
1 10 00000005 00000000
1 00 00000001 00000000
3 04 00000040 00000002
2 14 00000000 00000000
2 18 00000000 02bc0226
2 20 00000000 00000000
2 44 00000000 00b40090
0 00 00000006 00000000
4 1c 12345678 00000001
4 14 000003ff 00000001
2 14 00000000 00000000
2 18 00000000 02bc0226
f 00 00000000 00000000
